//--- all.f
uart_tx_pkg.sv
word_splitter.sv
async_fifo.sv
tx_fetch_fsm.sv
baud_timer.sv
uart_shifter.sv
word_uart_tx.sv
tb_word_uart_tx.sv

//--- async_fifo.sv
// dual-clock byte FIFO with gray-coded pointers and two-flop synchronizers
`timescale 1ns/1ps
`default_nettype none

module async_fifo (
    input  logic                 clk_wr,
    input  logic                 wr_rst_n,
    input  logic                 wr_en,
    input  uart_tx_pkg::byte_t   wr_data,
    output logic                 wr_full,
    input  logic                 clk_rd,
    input  logic                 rd_rst_n,
    input  logic                 rd_en,
    output uart_tx_pkg::byte_t   rd_data,
    output logic                 rd_empty
);
    import uart_tx_pkg::*;

    byte_t mem [0:(1 << FIFO_ADDR_W)-1];

    // write domain pointers, one extra bit for wrap
    logic [FIFO_ADDR_W:0] wr_bin;
    logic [FIFO_ADDR_W:0] wr_gray;
    logic [FIFO_ADDR_W:0] wr_bin_next;
    logic [FIFO_ADDR_W:0] wr_gray_next;
    logic [FIFO_ADDR_W:0] rd_gray_s1;
    logic [FIFO_ADDR_W:0] rd_gray_s2;
    logic                 wr_push;

    // read domain pointers
    logic [FIFO_ADDR_W:0] rd_bin;
    logic [FIFO_ADDR_W:0] rd_gray;
    logic [FIFO_ADDR_W:0] rd_bin_next;
    logic [FIFO_ADDR_W:0] rd_gray_next;
    logic [FIFO_ADDR_W:0] wr_gray_s1;
    logic [FIFO_ADDR_W:0] wr_gray_s2;
    logic                 rd_pop;

    assign wr_push      = wr_en && !wr_full;
    assign wr_bin_next  = wr_bin + {{FIFO_ADDR_W{1'b0}}, wr_push};
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

    assign rd_pop       = rd_en && !rd_empty;
    assign rd_bin_next  = rd_bin + {{FIFO_ADDR_W{1'b0}}, rd_pop};
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

    always_ff @(posedge clk_wr) begin
        if (wr_push) begin
            mem[wr_bin[FIFO_ADDR_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk_wr or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
            wr_full    <= 1'b0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_gray_next;
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            // full when the two msbs differ and the rest match
            wr_full    <= (wr_gray_next == {~rd_gray_s2[FIFO_ADDR_W -: 2],
                                            rd_gray_s2[FIFO_ADDR_W-2:0]});
        end
    end

    always_ff @(posedge clk_rd or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
            rd_empty   <= 1'b1;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_gray_next;
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            rd_empty   <= (rd_gray_next == wr_gray_s2);
        end
    end

    // registered read, valid the cycle after rd_en
    always_ff @(posedge clk_rd) begin
        if (rd_pop) begin
            rd_data <= mem[rd_bin[FIFO_ADDR_W-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- baud_timer.sv
// bit-period timer, one tick every clks_per_bit cycles while enabled
`timescale 1ns/1ps
`default_nettype none

module baud_timer #(
    parameter int unsigned clks_per_bit = uart_tx_pkg::DEF_CLKS_PER_BIT
) (
    input  logic clk_rd,
    input  logic rd_rst_n,
    input  logic bit_en,
    output logic bit_tick
);
    localparam int unsigned CNT_W = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

    logic [CNT_W-1:0] cnt;

    assign bit_tick = bit_en && (cnt == CNT_W'(clks_per_bit - 1));

    always_ff @(posedge clk_rd or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            cnt <= '0;
        end else if (!bit_en || bit_tick) begin
            // idle or end of a bit period
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tb_word_uart_tx.sv
// testbench for word_uart_tx, drives words from a data file and decodes the serial line
`timescale 1ns/1ps
`default_nettype none

module tb_word_uart_tx;
    import uart_tx_pkg::*;

    localparam int unsigned CLKS_PER_BIT = 16;

    logic  clk_wr;
    logic  clk_rd;
    logic  wr_rst_n;
    logic  rd_rst_n;
    logic  wr_req;
    word_t wr_data;
    logic  wr_busy;
    logic  rd_empty;
    logic  out_tx_data;
    logic  out_tx_en;

    word_t words[$];
    int    gaps[$];
    byte_t exp_q[$];
    int    byte_errs = 0;
    int    frame_errs = 0;
    int    cycle_cnt = 0;
    int    timeout_limit = 0;
    int    max_busy = 0;

    word_uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_word_uart_tx (
        .clk_wr      (clk_wr),
        .clk_rd      (clk_rd),
        .wr_rst_n    (wr_rst_n),
        .rd_rst_n    (rd_rst_n),
        .wr_req      (wr_req),
        .wr_data     (wr_data),
        .wr_busy     (wr_busy),
        .rd_empty    (rd_empty),
        .out_tx_data (out_tx_data),
        .out_tx_en   (out_tx_en)
    );

    initial begin
        clk_rd = 1'b0;
        forever #20 clk_rd = ~clk_rd;
    end

    initial begin
        clk_wr = 1'b0;
        forever #14 clk_wr = ~clk_wr;
    end

    task automatic check_byte(input byte_t got);
        byte_t exp;
        if (exp_q.size() == 0) begin
            $display("byte %h arrived at %0t with no byte left to send", got, $time);
            byte_errs++;
        end else begin
            exp = exp_q.pop_front();
            if (got !== exp) begin
                $display("[ERROR] %0t: byte mismatch, got %h expected %h", $time, got, exp);
                byte_errs++;
            end
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            frame_errs++;
        end
    endtask

    task automatic read_stimulus();
        int          fd;
        int          n;
        word_t       w;
        int          g;
        logic [8*100-1:0] line;
        fd = $fopen("word_uart_tx_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open word_uart_tx_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%h %d\n", w, g);
                if (n == 2) begin
                    words.push_back(w);
                    gaps.push_back(g);
                end else begin
                    // comment line
                    n = $fgets(line, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_words();
        int i;
        int k;
        int gap;
        int busy_len;
        for (i = 0; i < words.size(); i++) begin
            gap = (gaps[i] < 0) ? int'($urandom % 41) : gaps[i];
            repeat (gap) @(posedge clk_wr);
            @(posedge clk_wr);
            wr_req  <= 1'b1;
            wr_data <= words[i];
            // msb first on the line
            for (k = BYTES_PER_WORD - 1; k >= 0; k--) begin
                exp_q.push_back(words[i][k*$bits(byte_t) +: $bits(byte_t)]);
            end
            @(posedge clk_wr);
            wr_req <= 1'b0;
            // busy from the cycle after the request until the last byte is written
            @(negedge clk_wr);
            check_bit(wr_busy, 1'b1, "wr_busy after request");
            busy_len = 0;
            while (wr_busy) begin
                busy_len++;
                @(negedge clk_wr);
            end
            if (busy_len > max_busy) begin
                max_busy = busy_len;
            end
            // fifo still empty, so one byte per cycle
            if (i == 0) begin
                check_bit(busy_len == BYTES_PER_WORD, 1'b1, "first word wr_busy length");
            end
        end
    endtask

    // one frame, sampled mid-bit on the falling read clock
    task automatic receive_frame();
        byte_t got;
        int    i;
        @(negedge out_tx_data);
        repeat (CLKS_PER_BIT / 2) @(negedge clk_rd);
        check_bit(out_tx_data, 1'b0, "start bit");
        check_bit(out_tx_en, 1'b1, "out_tx_en in start bit");
        for (i = 0; i < $bits(byte_t); i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk_rd);
            got[i] = out_tx_data;
            check_bit(out_tx_en, 1'b1, "out_tx_en in data bit");
        end
        repeat (CLKS_PER_BIT) @(negedge clk_rd);
        check_bit(out_tx_data, 1'b1, "stop bit");
        check_bit(out_tx_en, 1'b1, "out_tx_en in stop bit");
        check_byte(got);
    endtask

    // watchdog on the read clock
    initial begin
        @(posedge clk_rd);
        while (cycle_cnt < timeout_limit) begin
            @(posedge clk_rd);
            cycle_cnt++;
        end
        $display("timeout: no end of run after %0d read cycles", timeout_limit);
        $display("test failed");
        $finish;
    end

    initial begin
        wr_rst_n = 1'b0;
        rd_rst_n = 1'b0;
        wr_req   = 1'b0;
        wr_data  = '0;
        void'($urandom(32'he46b));
        read_stimulus();
        if (words.size() == 0) begin
            $display("no words read from word_uart_tx_stimulus.txt");
            byte_errs++;
        end
        timeout_limit = words.size() * BYTES_PER_WORD * FRAME_BITS * (CLKS_PER_BIT + 4) + 2000;

        repeat (8) @(posedge clk_rd);
        rd_rst_n <= 1'b1;
        @(posedge clk_wr);
        wr_rst_n <= 1'b1;

        // idle line before any request
        repeat (20) begin
            @(negedge clk_rd);
            check_bit(out_tx_data, 1'b1, "idle out_tx_data");
            check_bit(out_tx_en, 1'b0, "idle out_tx_en");
            check_bit(rd_empty, 1'b1, "idle rd_empty");
            check_bit(wr_busy, 1'b0, "idle wr_busy");
        end

        fork
            drive_words();
            repeat (words.size() * BYTES_PER_WORD) receive_frame();
        join

        // the burst overruns the fifo, so the splitter has to wait on full
        check_bit(max_busy > BYTES_PER_WORD, 1'b1, "wr_busy stall in burst");

        @(negedge clk_rd);
        while (out_tx_en) @(negedge clk_rd);
        check_bit(rd_empty, 1'b1, "rd_empty after last frame");
        if (exp_q.size() != 0) begin
            $display("%0d expected bytes never appeared on the line", exp_q.size());
            byte_errs++;
        end

        $display("byte errors: %0d, framing errors: %0d", byte_errs, frame_errs);
        if (byte_errs + frame_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tx_fetch_fsm.sv
// read-side fetch FSM, pulls one byte from the FIFO and starts a frame
`timescale 1ns/1ps
`default_nettype none

module tx_fetch_fsm (
    input  logic                 clk_rd,
    input  logic                 rd_rst_n,
    input  logic                 rd_empty,
    input  logic                 tx_busy,
    output logic                 fifo_rd_en,
    input  uart_tx_pkg::byte_t   fifo_rd_data,
    output logic                 tx_load,
    output uart_tx_pkg::byte_t   tx_byte
);
    import uart_tx_pkg::*;

    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        FETCH = 2'b01,
        LOAD  = 2'b11
    } state_t;

    state_t state;
    byte_t  byte_cache;

    // read strobe lasts the single IDLE cycle that leaves for FETCH
    assign fifo_rd_en = (state == IDLE) && !rd_empty && !tx_busy;
    assign tx_load    = (state == LOAD);
    assign tx_byte    = byte_cache;

    always_ff @(posedge clk_rd or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (fifo_rd_en) begin
                        state <= FETCH;
                    end
                end
                FETCH:   state <= LOAD;
                LOAD:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // fifo output is valid during FETCH
    always_ff @(posedge clk_rd) begin
        if (state == FETCH) begin
            byte_cache <= fifo_rd_data;
        end
    end

endmodule

`default_nettype wire

//--- uart_shifter.sv
// 8N1 serializer, shifts a frame out lsb first on baud ticks
`timescale 1ns/1ps
`default_nettype none

module uart_shifter (
    input  logic                 clk_rd,
    input  logic                 rd_rst_n,
    input  logic                 tx_load,
    input  uart_tx_pkg::byte_t   tx_byte,
    input  logic                 bit_tick,
    output logic                 bit_en,
    output logic                 tx_busy,
    output logic                 tx_line
);
    import uart_tx_pkg::*;

    logic [FRAME_BITS-1:0]         frame_sr;
    logic [$clog2(FRAME_BITS)-1:0] bit_cnt;

    // line follows the lsb, all ones when idle
    assign tx_line = frame_sr[0];
    assign bit_en  = tx_busy;

    always_ff @(posedge clk_rd or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            frame_sr <= '1;
            bit_cnt  <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_load) begin
                // stop, data, start
                frame_sr <= {1'b1, tx_byte, 1'b0};
                bit_cnt  <= '0;
                tx_busy  <= 1'b1;
            end
        end else if (bit_tick) begin
            frame_sr <= {1'b1, frame_sr[FRAME_BITS-1:1]};
            if (bit_cnt == $bits(bit_cnt)'(FRAME_BITS - 1)) begin
                // end of stop bit
                tx_busy <= 1'b0;
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- uart_tx_pkg.sv
// shared types and constants for the word-to-UART transmit path
`default_nettype none

package uart_tx_pkg;

    // payload types
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    localparam int unsigned BYTES_PER_WORD = $bits(word_t) / $bits(byte_t);

    // wide enough to hold BYTES_PER_WORD itself
    localparam int unsigned BYTE_CNT_W = $clog2(BYTES_PER_WORD + 1);

    // 16-entry byte FIFO
    localparam int unsigned FIFO_ADDR_W = 4;

    // 8N1: start, eight data bits, stop
    localparam int unsigned FRAME_BITS = $bits(byte_t) + 2;

    // default line rate
    localparam int unsigned SYS_CLK = 50_000_000;
    localparam int unsigned BAUD    = 9600;

    localparam int unsigned DEF_CLKS_PER_BIT = SYS_CLK / BAUD;

endpackage

`default_nettype wire

//--- word_splitter.sv
// write-side splitter, pushes a 32-bit word into the byte FIFO msb first
`timescale 1ns/1ps
`default_nettype none

module word_splitter (
    input  logic                 clk_wr,
    input  logic                 wr_rst_n,
    input  logic                 wr_req,
    input  uart_tx_pkg::word_t   wr_data,
    input  logic                 wr_full,
    output logic                 wr_busy,
    output logic                 fifo_wr_en,
    output uart_tx_pkg::byte_t   fifo_wr_data
);
    import uart_tx_pkg::*;

    word_t                 word_q;
    logic [BYTE_CNT_W-1:0] byte_cnt;

    // busy while bytes remain
    assign wr_busy = (byte_cnt != '0);

    // stall on full, byte and count stay put
    assign fifo_wr_en = wr_busy && !wr_full;

    // top byte is always the one on offer
    assign fifo_wr_data = word_q[$bits(word_t)-1 -: $bits(byte_t)];

    always_ff @(posedge clk_wr or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            byte_cnt <= '0;
        end else if (!wr_busy) begin
            if (wr_req) begin
                byte_cnt <= BYTE_CNT_W'(BYTES_PER_WORD);
            end
        end else if (fifo_wr_en) begin
            byte_cnt <= byte_cnt - 1'b1;
        end
    end

    // word register, loaded when idle and shifted per accepted byte
    always_ff @(posedge clk_wr) begin
        if (!wr_busy && wr_req) begin
            word_q <= wr_data;
        end else if (fifo_wr_en) begin
            word_q <= word_q << $bits(byte_t);
        end
    end

endmodule

`default_nettype wire

//--- word_uart_tx.sv
// top level, word writes on clk_wr become 8N1 UART frames on clk_rd
`timescale 1ns/1ps
`default_nettype none

module word_uart_tx #(
    parameter int unsigned CLKS_PER_BIT = uart_tx_pkg::DEF_CLKS_PER_BIT
) (
    input  logic                 clk_wr,
    input  logic                 clk_rd,
    input  logic                 wr_rst_n,
    input  logic                 rd_rst_n,
    input  logic                 wr_req,
    input  uart_tx_pkg::word_t   wr_data,
    output logic                 wr_busy,
    output logic                 rd_empty,
    output logic                 out_tx_data,
    output logic                 out_tx_en
);
    import uart_tx_pkg::*;

    // write domain
    logic  fifo_wr_en;
    byte_t fifo_wr_data;
    logic  wr_full;

    // read domain
    logic  fifo_rd_en;
    byte_t fifo_rd_data;
    logic  tx_load;
    byte_t tx_byte;
    logic  bit_en;
    logic  bit_tick;

    word_splitter splitter_inst (
        .clk_wr       (clk_wr),
        .wr_rst_n     (wr_rst_n),
        .wr_req       (wr_req),
        .wr_data      (wr_data),
        .wr_full      (wr_full),
        .wr_busy      (wr_busy),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data)
    );

    async_fifo tx_fifo_inst (
        .clk_wr   (clk_wr),
        .wr_rst_n (wr_rst_n),
        .wr_en    (fifo_wr_en),
        .wr_data  (fifo_wr_data),
        .wr_full  (wr_full),
        .clk_rd   (clk_rd),
        .rd_rst_n (rd_rst_n),
        .rd_en    (fifo_rd_en),
        .rd_data  (fifo_rd_data),
        .rd_empty (rd_empty)
    );

    // out_tx_en doubles as the shifter busy flag
    tx_fetch_fsm fetch_inst (
        .clk_rd       (clk_rd),
        .rd_rst_n     (rd_rst_n),
        .rd_empty     (rd_empty),
        .tx_busy      (out_tx_en),
        .fifo_rd_en   (fifo_rd_en),
        .fifo_rd_data (fifo_rd_data),
        .tx_load      (tx_load),
        .tx_byte      (tx_byte)
    );

    baud_timer #(
        .clks_per_bit (CLKS_PER_BIT)
    ) baud_inst (
        .clk_rd   (clk_rd),
        .rd_rst_n (rd_rst_n),
        .bit_en   (bit_en),
        .bit_tick (bit_tick)
    );

    uart_shifter shifter_inst (
        .clk_rd   (clk_rd),
        .rd_rst_n (rd_rst_n),
        .tx_load  (tx_load),
        .tx_byte  (tx_byte),
        .bit_tick (bit_tick),
        .bit_en   (bit_en),
        .tx_busy  (out_tx_en),
        .tx_line  (out_tx_data)
    );

endmodule

`default_nettype wire

//--- word_uart_tx_stimulus.txt
// columns: 32-bit word in hex, idle gap in write cycles before it (-1 = random 0..40)
// one single word, then an 8-word back-to-back burst, then words with random gaps
1234abcd 5
00ff55aa 0
80017fe0 0
deadbeef 0
01020304 0
f0e1d2c3 0
7e7e8181 0
c0ffee00 0
5a3cc3a5 0
13579bdf -1
2468ace0 -1
ffffffff -1
00000000 -1
